// ==== src/dcache_macros.svh ====
// Size parameters of the data cache
// Included by the package and by every RTL file that needs a width or depth
`ifndef DCACHE_MACROS_SVH
`define DCACHE_MACROS_SVH

// ==============================
// Word and line
// ==============================

// Address and data word width
`define DC_XLEN 32

// Line width in bits, four words per line
`define DC_LINE_BITS 128

// ==============================
// Organisation
// ==============================

// 4 ways of 16 sets, 1 KB in total
`define DC_NUM_WAY 4
`define DC_NUM_SET 16

`endif

// ==== src/dcache_pkg.sv ====
// Types shared by the data cache RTL
// Field widths follow from the size macros
`include "dcache_macros.svh"

package dcache_pkg;

  // Address field widths
  localparam int IDX_W  = $clog2(`DC_NUM_SET);
  localparam int WORD_W = $clog2(`DC_LINE_BITS / `DC_XLEN);
  localparam int BYTE_W = $clog2(`DC_XLEN / 8);
  localparam int TAG_W  = `DC_XLEN - IDX_W - WORD_W - BYTE_W;

  typedef struct packed {
    logic [TAG_W-1:0]  tag;
    logic [IDX_W-1:0]  idx;
    logic [WORD_W-1:0] word;
    logic [BYTE_W-1:0] byte_off;
  } addr_fields_t;

  // Request address, as a raw word or split into its fields
  typedef union packed {
    logic [`DC_XLEN-1:0] raw;
    addr_fields_t        f;
  } addr_u;

  typedef enum logic [1:0] {
    BYTE = 2'd0,
    HALF = 2'd1,
    WORD = 2'd2
  } size_e;

  typedef logic [`DC_NUM_WAY-1:0] way_oh_t;

  typedef logic [`DC_LINE_BITS-1:0] line_t;

endpackage

// ==== src/dcache_if.sv ====
`timescale 1ns/1ps
// Interfaces between the cache controller and the two stores
// lookup_if returns the tag store result, array_wr_if drives both stores
`include "dcache_macros.svh"

// Registered lookup result of the tag store
interface lookup_if;
  logic                         hit;
  dcache_pkg::way_oh_t          hit_way;
  dcache_pkg::way_oh_t          victim_way;
  logic                         victim_dirty;
  logic [dcache_pkg::TAG_W-1:0] victim_tag;
  logic                         sweep_busy;

  modport store (output hit, hit_way, victim_way, victim_dirty, victim_tag, sweep_busy);
  modport ctrl (input hit, hit_way, victim_way, victim_dirty, victim_tag, sweep_busy);
endinterface

// Lookup strobe and write path shared by the tag and data stores
interface array_wr_if;
  logic                          rd_en;
  logic [dcache_pkg::IDX_W-1:0]  idx;
  dcache_pkg::way_oh_t           way_we;
  logic                          is_fill;
  dcache_pkg::line_t             fill_line;
  logic [`DC_XLEN-1:0]           store_data;
  dcache_pkg::size_e             size;
  logic [dcache_pkg::WORD_W-1:0] word_sel;
  logic [dcache_pkg::BYTE_W-1:0] byte_off;
  logic [dcache_pkg::TAG_W-1:0]  tag;
  logic                          set_dirty;

  modport ctrl (output rd_en, idx, way_we, is_fill, fill_line, store_data, size, word_sel,
                byte_off, tag, set_dirty);
  modport store (input rd_en, idx, way_we, is_fill, fill_line, store_data, size, word_sel,
                 byte_off, tag, set_dirty);
endinterface

// ==== src/dcache_tag_store.sv ====
`timescale 1ns/1ps
// Tag, valid and dirty bits per way and set, with a 3-bit PLRU tree per set
// Compares tags on a lookup strobe and registers hit and victim information
// Runs an invalidation sweep after reset and on flush
`include "dcache_macros.svh"

module dcache_tag_store (
  input  logic       clk_i,
  input  logic       rst_ni,
  input  logic       flush_i,
  lookup_if.store    lkp,
  array_wr_if.store  wr
);

  localparam logic [dcache_pkg::IDX_W-1:0] LAST_SET = dcache_pkg::IDX_W'(`DC_NUM_SET - 1);

  logic [`DC_NUM_WAY-1:0]       valid_q [`DC_NUM_SET];
  logic [`DC_NUM_WAY-1:0]       dirty_q [`DC_NUM_SET];
  logic [dcache_pkg::TAG_W-1:0] tag_q   [`DC_NUM_SET][`DC_NUM_WAY];
  logic [`DC_NUM_WAY-2:0]       plru_q  [`DC_NUM_SET];

  logic                         sweep_busy_q;
  logic [dcache_pkg::IDX_W-1:0] sweep_idx_q;

  logic [`DC_NUM_WAY-1:0]       valid_set;
  dcache_pkg::way_oh_t          hit_way_c;
  dcache_pkg::way_oh_t          plru_way;
  dcache_pkg::way_oh_t          victim_c;
  logic                         vic_dirty_c;
  logic [dcache_pkg::TAG_W-1:0] vic_tag_c;

  dcache_pkg::way_oh_t          hit_way_q;
  dcache_pkg::way_oh_t          victim_way_q;
  logic                         victim_dirty_q;
  logic [dcache_pkg::TAG_W-1:0] victim_tag_q;

  // Root picks the half, the lower nodes pick the way inside it
  function automatic dcache_pkg::way_oh_t plru_victim(input logic [`DC_NUM_WAY-2:0] tree);
    dcache_pkg::way_oh_t v;
    v = '0;
    v[tree[0] ? {1'b1, tree[2]} : {1'b0, tree[1]}] = 1'b1;
    return v;
  endfunction

  // Point every node on the path away from the used way
  function automatic logic [`DC_NUM_WAY-2:0] plru_touch(input logic [`DC_NUM_WAY-2:0] tree,
                                                       input dcache_pkg::way_oh_t way);
    logic [`DC_NUM_WAY-2:0] t;
    t = tree;
    if (way[0] || way[1]) begin
      t[0] = 1'b1;
      t[1] = way[0];
    end else if (way[2] || way[3]) begin
      t[0] = 1'b0;
      t[2] = way[2];
    end
    return t;
  endfunction

  // ==============================
  // Lookup
  // ==============================
  always_comb begin
    valid_set = valid_q[wr.idx];
    plru_way  = plru_victim(plru_q[wr.idx]);
    for (int w = 0; w < `DC_NUM_WAY; w++) begin
      hit_way_c[w] = valid_set[w] && (tag_q[wr.idx][w] == wr.tag);
    end
    // Tree pointing at a valid way while another is free
    victim_c = plru_way;
    if (|(plru_way & valid_set)) begin
      for (int w = `DC_NUM_WAY - 1; w >= 0; w--) begin
        if (!valid_set[w]) victim_c = dcache_pkg::way_oh_t'(1) << w;
      end
    end
    vic_dirty_c = 1'b0;
    vic_tag_c   = '0;
    for (int w = 0; w < `DC_NUM_WAY; w++) begin
      if (victim_c[w]) begin
        vic_dirty_c = valid_set[w] && dirty_q[wr.idx][w];
        vic_tag_c   = tag_q[wr.idx][w];
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (!rst_ni) begin
      hit_way_q <= '0;
    end else if (wr.rd_en) begin
      hit_way_q <= hit_way_c;
    end
  end

  always_ff @(posedge clk_i) begin
    if (wr.rd_en) begin
      victim_way_q   <= victim_c;
      victim_dirty_q <= vic_dirty_c;
      victim_tag_q   <= vic_tag_c;
    end
  end

  assign lkp.hit          = |hit_way_q;
  assign lkp.hit_way      = hit_way_q;
  assign lkp.victim_way   = victim_way_q;
  assign lkp.victim_dirty = victim_dirty_q;
  assign lkp.victim_tag   = victim_tag_q;
  assign lkp.sweep_busy   = sweep_busy_q;

  // ==============================
  // Array update and sweep
  // ==============================
  always_ff @(posedge clk_i) begin
    for (int w = 0; w < `DC_NUM_WAY; w++) begin
      if (wr.way_we[w]) begin
        if (wr.is_fill) begin
          valid_q[wr.idx][w] <= 1'b1;
          tag_q[wr.idx][w]   <= wr.tag;
        end
        dirty_q[wr.idx][w] <= wr.set_dirty;
      end
    end
    if (wr.rd_en && |hit_way_c) begin
      plru_q[wr.idx] <= plru_touch(plru_q[wr.idx], hit_way_c);
    end else if (|wr.way_we) begin
      plru_q[wr.idx] <= plru_touch(plru_q[wr.idx], wr.way_we);
    end
    // Sweep clears last so it wins over a write to the same set
    if (sweep_busy_q) begin
      valid_q[sweep_idx_q] <= '0;
      dirty_q[sweep_idx_q] <= '0;
      plru_q[sweep_idx_q]  <= '0;
    end
  end

  always_ff @(posedge clk_i) begin
    if (!rst_ni) begin
      sweep_busy_q <= 1'b1;
      sweep_idx_q  <= '0;
    end else if (sweep_busy_q) begin
      sweep_idx_q <= sweep_idx_q + 1'b1;
      if (sweep_idx_q == LAST_SET) sweep_busy_q <= 1'b0;
    end else if (flush_i && !wr.rd_en && wr.way_we == '0) begin
      sweep_busy_q <= 1'b1;
      sweep_idx_q  <= '0;
    end
  end

  // A fill never leaves two valid copies of one tag in a set
  hit_onehot_a: assert property (@(posedge clk_i) disable iff (!rst_ni)
    wr.rd_en |-> $onehot0(hit_way_c));

endmodule

// ==== src/dcache_data_store.sv ====
`timescale 1ns/1ps
// Line data array of the cache with a registered read of all ways
// Writes take a fill line or merge store bytes into a stored line
`include "dcache_macros.svh"

module dcache_data_store (
  input  logic                                clk_i,
  array_wr_if.store                           wr,
  output dcache_pkg::line_t [`DC_NUM_WAY-1:0] rd_line_o
);

  localparam int OFF_W = dcache_pkg::WORD_W + dcache_pkg::BYTE_W;

  dcache_pkg::line_t mem_q [`DC_NUM_SET][`DC_NUM_WAY];
  dcache_pkg::line_t fill_merged;
  logic [OFF_W-1:0]  pos;

  // Little-endian placement of the store bytes by line offset
  function automatic dcache_pkg::line_t merge_store(input dcache_pkg::line_t line,
                                                    input logic [`DC_XLEN-1:0] data,
                                                    input dcache_pkg::size_e size,
                                                    input logic [OFF_W-1:0] off);
    dcache_pkg::line_t merged;
    merged = line;
    case (size)
      dcache_pkg::BYTE: merged[off*8 +: 8] = data[7:0];
      dcache_pkg::HALF: merged[off[OFF_W-1:1]*16 +: 16] = data[15:0];
      default:          merged[off[OFF_W-1:2]*32 +: 32] = data;
    endcase
    return merged;
  endfunction

  assign pos = {wr.word_sel, wr.byte_off};

  // Store miss writes the fetched line with its store already applied
  always_comb begin
    fill_merged = wr.fill_line;
    if (wr.set_dirty) begin
      fill_merged = merge_store(wr.fill_line, wr.store_data, wr.size, pos);
    end
  end

  always_ff @(posedge clk_i) begin
    for (int w = 0; w < `DC_NUM_WAY; w++) begin
      if (wr.way_we[w]) begin
        if (wr.is_fill) begin
          mem_q[wr.idx][w] <= fill_merged;
        end else begin
          mem_q[wr.idx][w] <= merge_store(mem_q[wr.idx][w], wr.store_data, wr.size, pos);
        end
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (wr.rd_en) begin
      for (int w = 0; w < `DC_NUM_WAY; w++) begin
        rd_line_o[w] <= mem_q[wr.idx][w];
      end
    end
  end

  // Hit and victim ways from the tag store only ever select one way
  way_we_onehot_a: assert property (@(posedge clk_i)
    wr.way_we != '0 |-> $onehot(wr.way_we));

endmodule

// ==== src/dcache_ctrl.sv ====
`timescale 1ns/1ps
// Cache controller FSM with one request in flight at a time
// Decides hit or miss from the tag store, runs write-back and line fill
// on the memory port and returns one response per request
`include "dcache_macros.svh"

module dcache_ctrl (
  input  logic                                clk_i,
  input  logic                                rst_ni,
  // CPU request and response
  input  logic                                req_valid_i,
  output logic                                req_ready_o,
  input  logic                                req_we_i,
  input  logic [1:0]                          req_size_i,
  input  logic [`DC_XLEN-1:0]                 req_addr_i,
  input  logic [`DC_XLEN-1:0]                 req_wdata_i,
  output logic                                resp_valid_o,
  output logic [`DC_XLEN-1:0]                 resp_rdata_o,
  // Memory port
  output logic                                mem_req_valid_o,
  output logic                                mem_req_we_o,
  output logic [`DC_XLEN-1:0]                 mem_req_addr_o,
  output logic [`DC_LINE_BITS-1:0]            mem_req_wdata_o,
  input  logic                                mem_req_ready_i,
  input  logic                                mem_resp_valid_i,
  input  logic [`DC_LINE_BITS-1:0]            mem_resp_rdata_i,
  // Stores
  lookup_if.ctrl                              lkp,
  array_wr_if.ctrl                            wr,
  input  dcache_pkg::line_t [`DC_NUM_WAY-1:0] rd_line_i
);

  typedef enum logic [2:0] {
    IDLE,
    LOOKUP,
    WRITEBACK,
    FILL,
    RESPOND
  } state_e;

  state_e              state_q;
  state_e              state_d;
  logic                rd_sent_q;
  logic                filled_q;

  dcache_pkg::addr_u   req_q;
  dcache_pkg::size_e   size_q;
  logic                we_q;
  logic [`DC_XLEN-1:0] wdata_q;
  logic [`DC_XLEN-1:0] rdata_q;

  logic                accept;
  logic                hit_done;
  logic                fill_done;
  dcache_pkg::line_t   hit_line;
  dcache_pkg::line_t   victim_line;
  dcache_pkg::addr_u   mem_addr;

  assign req_ready_o = (state_q == IDLE) && !lkp.sweep_busy;
  assign accept      = req_valid_i && req_ready_o;
  assign hit_done    = (state_q == RESPOND) && lkp.hit && !filled_q;
  assign fill_done   = (state_q == FILL) && rd_sent_q && mem_resp_valid_i;

  // ==============================
  // Way selection and response
  // ==============================
  always_comb begin
    hit_line    = '0;
    victim_line = '0;
    for (int w = 0; w < `DC_NUM_WAY; w++) begin
      if (lkp.hit_way[w]) hit_line = rd_line_i[w];
      if (lkp.victim_way[w]) victim_line = rd_line_i[w];
    end
  end

  assign resp_valid_o = (state_q == RESPOND) && (filled_q || lkp.hit);
  assign resp_rdata_o = filled_q ? rdata_q : hit_line[req_q.f.word*`DC_XLEN +: `DC_XLEN];

  // Line address of the victim during write-back, of the request otherwise
  always_comb begin
    mem_addr            = req_q;
    mem_addr.f.word     = '0;
    mem_addr.f.byte_off = '0;
    if (state_q == WRITEBACK) mem_addr.f.tag = lkp.victim_tag;
  end

  assign mem_req_valid_o = (state_q == WRITEBACK) || (state_q == FILL && !rd_sent_q);
  assign mem_req_we_o    = (state_q == WRITEBACK);
  assign mem_req_addr_o  = mem_addr.raw;
  assign mem_req_wdata_o = victim_line;

  // ==============================
  // Store array control
  // ==============================
  assign wr.rd_en      = (state_q == LOOKUP) && !lkp.sweep_busy;
  assign wr.idx        = req_q.f.idx;
  assign wr.tag        = req_q.f.tag;
  assign wr.word_sel   = req_q.f.word;
  assign wr.byte_off   = req_q.f.byte_off;
  assign wr.size       = size_q;
  assign wr.store_data = wdata_q;
  assign wr.set_dirty  = we_q;
  assign wr.is_fill    = (state_q == FILL);
  assign wr.fill_line  = mem_resp_rdata_i;

  always_comb begin
    wr.way_we = '0;
    if (fill_done) begin
      wr.way_we = lkp.victim_way;
    end else if (hit_done && we_q) begin
      wr.way_we = lkp.hit_way;
    end
  end

  // ==============================
  // FSM
  // ==============================
  always_comb begin
    state_d = state_q;
    unique case (state_q)
      IDLE:      if (accept) state_d = LOOKUP;
      LOOKUP:    if (!lkp.sweep_busy) state_d = RESPOND;
      RESPOND: begin
        if (filled_q || lkp.hit) begin
          state_d = IDLE;
        end else if (lkp.victim_dirty) begin
          state_d = WRITEBACK;
        end else begin
          state_d = FILL;
        end
      end
      WRITEBACK: if (mem_req_ready_i) state_d = FILL;
      FILL:      if (fill_done) state_d = RESPOND;
      default:   state_d = IDLE;
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (!rst_ni) begin
      state_q   <= IDLE;
      rd_sent_q <= 1'b0;
      filled_q  <= 1'b0;
    end else begin
      state_q <= state_d;
      if (fill_done) begin
        rd_sent_q <= 1'b0;
      end else if (state_q == FILL && mem_req_valid_o && mem_req_ready_i) begin
        rd_sent_q <= 1'b1;
      end
      if (fill_done) begin
        filled_q <= 1'b1;
      end else if (state_q == RESPOND) begin
        filled_q <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (accept) begin
      req_q.raw <= req_addr_i;
      we_q      <= req_we_i;
      size_q    <= dcache_pkg::size_e'(req_size_i);
      wdata_q   <= req_wdata_i;
    end
    if (fill_done) begin
      rdata_q <= mem_resp_rdata_i[req_q.f.word*`DC_XLEN +: `DC_XLEN];
    end
  end

  // Memory request held with a stable address until accepted
  mem_hold_a: assert property (@(posedge clk_i) disable iff (!rst_ni)
    mem_req_valid_o && !mem_req_ready_i |=> mem_req_valid_o && $stable(mem_req_addr_o));

endmodule

// ==== src/dcache_top.sv ====
`timescale 1ns/1ps
// Top level of the 4-way write-back data cache
// Connects the CPU load/store port and the line-wide memory port
`include "dcache_macros.svh"

module dcache_top (
  input  logic                     clk_i,
  input  logic                     rst_ni,
  input  logic                     flush_i,
  // CPU request and response
  input  logic                     req_valid_i,
  output logic                     req_ready_o,
  input  logic                     req_we_i,
  input  logic [1:0]               req_size_i,
  input  logic [`DC_XLEN-1:0]      req_addr_i,
  input  logic [`DC_XLEN-1:0]      req_wdata_i,
  output logic                     resp_valid_o,
  output logic [`DC_XLEN-1:0]      resp_rdata_o,
  // Memory port
  output logic                     mem_req_valid_o,
  output logic                     mem_req_we_o,
  output logic [`DC_XLEN-1:0]      mem_req_addr_o,
  output logic [`DC_LINE_BITS-1:0] mem_req_wdata_o,
  input  logic                     mem_req_ready_i,
  input  logic                     mem_resp_valid_i,
  input  logic [`DC_LINE_BITS-1:0] mem_resp_rdata_i
);

  lookup_if   lkp_bus ();
  array_wr_if wr_bus ();

  dcache_pkg::line_t [`DC_NUM_WAY-1:0] rd_lines;

  dcache_tag_store tag_store_inst (
    .clk_i  (clk_i),
    .rst_ni (rst_ni),
    .flush_i(flush_i),
    .lkp    (lkp_bus),
    .wr     (wr_bus)
  );

  dcache_data_store data_store_inst (
    .clk_i    (clk_i),
    .wr       (wr_bus),
    .rd_line_o(rd_lines)
  );

  dcache_ctrl ctrl_inst (
    .clk_i           (clk_i),
    .rst_ni          (rst_ni),
    .req_valid_i     (req_valid_i),
    .req_ready_o     (req_ready_o),
    .req_we_i        (req_we_i),
    .req_size_i      (req_size_i),
    .req_addr_i      (req_addr_i),
    .req_wdata_i     (req_wdata_i),
    .resp_valid_o    (resp_valid_o),
    .resp_rdata_o    (resp_rdata_o),
    .mem_req_valid_o (mem_req_valid_o),
    .mem_req_we_o    (mem_req_we_o),
    .mem_req_addr_o  (mem_req_addr_o),
    .mem_req_wdata_o (mem_req_wdata_o),
    .mem_req_ready_i (mem_req_ready_i),
    .mem_resp_valid_i(mem_resp_valid_i),
    .mem_resp_rdata_i(mem_resp_rdata_i),
    .lkp             (lkp_bus),
    .wr              (wr_bus),
    .rd_line_i       (rd_lines)
  );

endmodule

// ==== bench/dcache_checker.sv ====
`timescale 1ns/1ps
// Watches the cache ports and compares load data, write-backs and hit latency
// Expected values come from the current pattern line driven by the testbench
`include "dcache_macros.svh"

module dcache_checker (
  input logic                     clk_i,
  input logic                     rst_ni,
  input logic                     req_valid_i,
  input logic                     req_ready_i,
  input logic                     req_we_i,
  input logic [1:0]               req_size_i,
  input logic [`DC_XLEN-1:0]      req_addr_i,
  input logic [`DC_XLEN-1:0]      req_wdata_i,
  input logic                     resp_valid_i,
  input logic [`DC_XLEN-1:0]      resp_rdata_i,
  input logic                     mem_valid_i,
  input logic                     mem_we_i,
  input logic [`DC_XLEN-1:0]      mem_addr_i,
  input logic [`DC_LINE_BITS-1:0] mem_wdata_i,
  input logic                     mem_ready_i,
  input logic [`DC_XLEN-1:0]      exp_data_i,
  input logic [`DC_XLEN-1:0]      exp_wb_i,
  input logic [3:0]               exp_lat_i
);

  localparam logic [`DC_XLEN-1:0] NO_WB = '1;

  int errors = 0;

  // CPU view of every stored word, unwritten words read as their address
  logic [`DC_XLEN-1:0] ref_words [logic [`DC_XLEN-1:0]];

  logic                busy = 1'b0;
  int                  cnt;
  logic                wb_seen;
  dcache_pkg::addr_u   cur;
  logic                cur_we;
  logic [`DC_XLEN-1:0] cur_exp;
  logic [`DC_XLEN-1:0] cur_wb;
  logic [3:0]          cur_lat;

  function automatic logic [`DC_XLEN-1:0] ref_word(input logic [`DC_XLEN-1:0] a);
    if (ref_words.exists(a)) return ref_words[a];
    return a;
  endfunction

  // Little-endian placement by byte offset
  task automatic apply_store(input dcache_pkg::addr_u a, input logic [1:0] size,
                             input logic [`DC_XLEN-1:0] data);
    dcache_pkg::addr_u wa;
    logic [`DC_XLEN-1:0] w;
    wa = a;
    wa.f.byte_off = '0;
    w = ref_word(wa.raw);
    case (size)
      2'd0:    w[a.f.byte_off*8 +: 8] = data[7:0];
      2'd1:    w[a.f.byte_off[1]*16 +: 16] = data[15:0];
      default: w = data;
    endcase
    ref_words[wa.raw] = w;
  endtask

  task automatic check_writeback();
    dcache_pkg::addr_u wa;
    dcache_pkg::addr_u exp_wa;
    wb_seen = 1'b1;
    // Victim sits in the set of the request
    exp_wa.raw   = cur_wb;
    exp_wa.f.idx = cur.f.idx;
    if (cur_wb == NO_WB || mem_addr_i != exp_wa.raw) begin
      $display("[FAIL] %0t: write-back to 0x%08h, expected 0x%08h", $time, mem_addr_i,
               exp_wa.raw);
      errors++;
    end
    for (int w = 0; w < 4; w++) begin
      wa.raw = mem_addr_i;
      wa.f.word = w[1:0];
      if (mem_wdata_i[w*32 +: 32] != ref_word(wa.raw)) begin
        $display("[FAIL] %0t: write-back word 0x%08h is 0x%08h, expected 0x%08h", $time,
                 wa.raw, mem_wdata_i[w*32 +: 32], ref_word(wa.raw));
        errors++;
      end
    end
  endtask

  always @(posedge clk_i) begin
    if (rst_ni) begin
      if (busy) cnt++;
      if (busy && mem_valid_i && mem_ready_i) begin
        if (mem_we_i) begin
          check_writeback();
        end else if (cur_wb != NO_WB && !wb_seen) begin
          $display("[FAIL] %0t: fill read of 0x%08h before write-back", $time, mem_addr_i);
          errors++;
        end
      end
      if (busy && resp_valid_i) begin
        busy = 1'b0;
        if (!cur_we && resp_rdata_i != cur_exp) begin
          $display("[FAIL] %0t: load 0x%08h returned 0x%08h, expected 0x%08h", $time,
                   cur.raw, resp_rdata_i, cur_exp);
          errors++;
        end
        if (cur_wb != NO_WB && !wb_seen) begin
          $display("[FAIL] %0t: no write-back to 0x%08h seen", $time, cur_wb);
          errors++;
        end
        if (cur_lat != 4'd0 && cnt != int'(cur_lat)) begin
          $display("[FAIL] %0t: hit on 0x%08h took %0d cycles", $time, cur.raw, cnt);
          errors++;
        end
      end else if (resp_valid_i) begin
        $display("[FAIL] %0t: response without an open request", $time);
        errors++;
      end
      if (req_valid_i && req_ready_i) begin
        busy    = 1'b1;
        cnt     = 0;
        wb_seen = 1'b0;
        cur.raw = req_addr_i;
        cur_we  = req_we_i;
        cur_exp = exp_data_i;
        cur_wb  = exp_wb_i;
        cur_lat = exp_lat_i;
        if (req_we_i) apply_store(cur, req_size_i, req_wdata_i);
      end
    end
  end

endmodule

// ==== bench/dcache_tb.sv ====
`timescale 1ns/1ps
// Testbench of the data cache with a line memory model of random latency
// Runs the accesses listed in the pattern file and reports the result
`include "dcache_macros.svh"

module dcache_tb;

  logic                     clk_i = 1'b0;
  logic                     rst_ni;
  logic                     flush_i;
  logic                     req_valid_i;
  logic                     req_ready_o;
  logic                     req_we_i;
  logic [1:0]               req_size_i;
  logic [`DC_XLEN-1:0]      req_addr_i;
  logic [`DC_XLEN-1:0]      req_wdata_i;
  logic                     resp_valid_o;
  logic [`DC_XLEN-1:0]      resp_rdata_o;
  logic                     mem_req_valid_o;
  logic                     mem_req_we_o;
  logic [`DC_XLEN-1:0]      mem_req_addr_o;
  logic [`DC_LINE_BITS-1:0] mem_req_wdata_o;
  logic                     mem_req_ready_i = 1'b0;
  logic                     mem_resp_valid_i = 1'b0;
  logic [`DC_LINE_BITS-1:0] mem_resp_rdata_i = '0;

  logic [`DC_XLEN-1:0] exp_data;
  logic [`DC_XLEN-1:0] exp_wb;
  logic [3:0]          exp_lat;
  int                  timeouts = 0;

  always #10 clk_i = ~clk_i;

  dcache_top dcache_top_inst (.*);

  dcache_checker checker_inst (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .req_valid_i (req_valid_i),
    .req_ready_i (req_ready_o),
    .req_we_i    (req_we_i),
    .req_size_i  (req_size_i),
    .req_addr_i  (req_addr_i),
    .req_wdata_i (req_wdata_i),
    .resp_valid_i(resp_valid_o),
    .resp_rdata_i(resp_rdata_o),
    .mem_valid_i (mem_req_valid_o),
    .mem_we_i    (mem_req_we_o),
    .mem_addr_i  (mem_req_addr_o),
    .mem_wdata_i (mem_req_wdata_o),
    .mem_ready_i (mem_req_ready_i),
    .exp_data_i  (exp_data),
    .exp_wb_i    (exp_wb),
    .exp_lat_i   (exp_lat)
  );

  // ==============================
  // Line memory model
  // ==============================
  dcache_pkg::line_t mem_lines [256];
  dcache_pkg::addr_u mem_a;
  int unsigned       seed = 75770;
  int                wait_cnt = 0;
  int                resp_cnt = 0;
  logic [7:0]        resp_line;

  // Delay of 1 to 4 cycles from a linear congruential generator
  function automatic int next_delay(inout int unsigned s);
    s = s * 32'd1103515245 + 32'd12345;
    return int'((s >> 16) % 4) + 1;
  endfunction

  always_comb mem_a.raw = mem_req_addr_o;

  always @(posedge clk_i) begin
    mem_req_ready_i  <= 1'b0;
    mem_resp_valid_i <= 1'b0;
    if (!rst_ni) begin
      // Each word holds its own byte address
      for (int l = 0; l < 256; l++) begin
        for (int w = 0; w < 4; w++) begin
          mem_lines[l][w*32 +: 32] <= 32'((l << 4) | (w << 2));
        end
      end
      wait_cnt <= 0;
      resp_cnt <= 0;
    end else begin
      if (resp_cnt == 1) begin
        mem_resp_valid_i <= 1'b1;
        mem_resp_rdata_i <= mem_lines[resp_line];
      end
      if (resp_cnt != 0) resp_cnt <= resp_cnt - 1;
      if (mem_req_valid_o && mem_req_ready_i) begin
        wait_cnt <= 0;
        if (mem_req_we_o) begin
          mem_lines[{mem_a.f.tag[3:0], mem_a.f.idx}] <= mem_req_wdata_o;
        end else begin
          resp_line <= {mem_a.f.tag[3:0], mem_a.f.idx};
          resp_cnt  <= next_delay(seed);
        end
      end else if (mem_req_valid_o) begin
        if (wait_cnt == 0) begin
          wait_cnt <= next_delay(seed);
        end else if (wait_cnt == 1) begin
          mem_req_ready_i <= 1'b1;
          wait_cnt        <= 0;
        end else begin
          wait_cnt <= wait_cnt - 1;
        end
      end
    end
  end

  // ==============================
  // Stimulus
  // ==============================
  task automatic run_access(input byte op, input logic [31:0] addr, input int size,
                            input logic [31:0] wdata);
    int n;
    req_valid_i <= 1'b1;
    req_we_i    <= (op == "S");
    req_size_i  <= 2'(size);
    req_addr_i  <= addr;
    req_wdata_i <= wdata;
    n = 0;
    do begin
      @(posedge clk_i);
      n++;
    end while (!req_ready_o && n < 200);
    req_valid_i <= 1'b0;
    if (!req_ready_o) begin
      $display("Timeout: request to 0x%08h was never accepted", addr);
      timeouts++;
      return;
    end
    n = 0;
    do begin
      @(posedge clk_i);
      n++;
    end while (!resp_valid_o && n < 200);
    if (!resp_valid_o) begin
      $display("Timeout: no response for the access to 0x%08h", addr);
      timeouts++;
    end
  endtask

  initial begin
    int          fd;
    int          n;
    string       line;
    byte         op;
    logic [31:0] addr;
    int          size;
    logic [31:0] wdata;
    logic [31:0] expd;
    logic [31:0] wb;
    int          lat;
    rst_ni      = 1'b0;
    flush_i     = 1'b0;
    req_valid_i = 1'b0;
    req_we_i    = 1'b0;
    req_size_i  = 2'd0;
    req_addr_i  = '0;
    req_wdata_i = '0;
    exp_data    = '0;
    exp_wb      = '1;
    exp_lat     = 4'd0;
    repeat (10) @(posedge clk_i);
    rst_ni <= 1'b1;
    fd = $fopen("bench/dcache_patterns.txt", "r");
    if (fd == 0) begin
      $display("Could not open the pattern file");
      timeouts++;
    end else begin
      while (!$feof(fd)) begin
        line = "";
        n = $fgets(line, fd);
        if (n == 0 || line.len() == 0 || line[0] == "#") continue;
        n = $sscanf(line, "%c %h %d %h %h %h %d", op, addr, size, wdata, expd, wb, lat);
        if (n != 7) continue;
        exp_data <= expd;
        exp_wb   <= wb;
        exp_lat  <= 4'(lat);
        if (op == "F") begin
          flush_i <= 1'b1;
          @(posedge clk_i);
          flush_i <= 1'b0;
          @(posedge clk_i);
        end else begin
          run_access(op, addr, size, wdata);
        end
      end
      $fclose(fd);
    end
    repeat (4) @(posedge clk_i);
    $display("Errors: %0d compare, %0d timeout", checker_inst.errors, timeouts);
    if (checker_inst.errors == 0 && timeouts == 0) begin
      $display("TESTS PASSED");
    end else begin
      $display("TESTS FAILED");
    end
    $finish;
  end

endmodule

// ==== dcache_top.f ====
+incdir+src
src/dcache_pkg.sv
src/dcache_if.sv
src/dcache_tag_store.sv
src/dcache_data_store.sv
src/dcache_ctrl.sv
src/dcache_top.sv
bench/dcache_checker.sv
bench/dcache_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build the data cache testbench with Verilator and run it

cd "$(dirname "$0")" || exit 1

verilator --binary --assert --top-module dcache_tb -f dcache_top.f -o dcache_sim
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

out=$(./obj_dir/dcache_sim)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if echo "$out" | grep -q "^TESTS PASSED$"; then
  exit 0
fi
exit 1

// ==== bench/dcache_patterns.txt ====
# op addr size(0 byte,1 half,2 word) wdata expected_rdata expected_wb_addr(ffffffff none) hit_lat
# op: L load, S store, F flush
L 00000014 2 00000000 00000014 ffffffff 0
L 00000014 2 00000000 00000014 ffffffff 2
S 00000018 2 deadbeef 00000000 ffffffff 2
L 00000018 2 00000000 deadbeef ffffffff 2
S 0000001d 0 000000aa 00000000 ffffffff 2
S 0000001e 1 00001234 00000000 ffffffff 2
L 0000001c 2 00000000 1234aa1c ffffffff 2
S 00000110 2 11111111 00000000 ffffffff 0
S 00000210 2 22222222 00000000 ffffffff 0
S 00000310 2 33333333 00000000 ffffffff 0
L 00000010 2 00000000 00000010 ffffffff 2
L 00000410 2 00000000 00000410 00000100 0
L 00000110 2 00000000 11111111 00000200 0
L 00000210 2 00000000 22222222 00000300 0
L 0000001c 2 00000000 1234aa1c ffffffff 2
L 00000314 2 00000000 00000314 ffffffff 0
S 00000024 2 55555555 00000000 ffffffff 0
F 00000000 0 00000000 00000000 ffffffff 0
L 00000024 2 00000000 00000024 ffffffff 0
L 00000018 2 00000000 00000018 ffffffff 0
L 00000018 2 00000000 00000018 ffffffff 2
